// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    // one machine word for data, ALU results and memory cells
    localparam int word_size = 16;

    // architectural register file of the back end
    localparam int num_regs = 4;

    // register index wide enough for every architectural register
    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;

    // data memory geometry
    localparam int mem_depth = 256;          // words in the data RAM
    localparam int mem_addr_w = 8;           // low ALU result bits used as the word address

    // the address width and the depth have to describe the same RAM
    localparam bit mem_geom_ok = ((1 << mem_addr_w) == mem_depth);

endpackage

// ==== hw/stage_if.sv ====
`timescale 1ns/100ps

// one retired result on its way from the MEM/WB register to writeback
interface stage_if;

    logic                           valid;
    logic                           ready;
    logic [cpu_pkg::word_size-1:0]  alu_result;
    cpu_pkg::reg_idx_t              rd;
    logic                           mem_to_reg;
    logic                           reg_write;

    // the source holds every field stable while valid is high and ready is low
    modport source (
        output valid, alu_result, rd, mem_to_reg, reg_write,
        input  ready
    );

    modport sink (
        input  valid, alu_result, rd, mem_to_reg, reg_write,
        output ready
    );

endinterface

// ==== hw/mem_wb_reg.sv ====
`timescale 1ns/100ps

module mem_wb_reg (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [cpu_pkg::word_size-1:0]   alu_result,
    input  cpu_pkg::reg_idx_t               rd,
    input  logic                            mem_to_reg,
    input  logic                            reg_write,
    output logic                            accept,
    stage_if.source                         out
);

    logic                           full;
    logic [cpu_pkg::word_size-1:0]  alu_result_q;
    cpu_pkg::reg_idx_t              rd_q;
    logic                           mem_to_reg_q;
    logic                           reg_write_q;

    // an empty entry, or one that retires this cycle, can take a new result
    assign in_ready = !full || out.ready;
    assign accept   = in_valid && in_ready;    // also tells the data memory to act

    always_ff @(posedge clk) begin
        if (reset_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (out.ready) begin
            full <= 1'b0;                      // old entry left and nothing replaced it
        end
    end

    // payload only moves on accept, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_result_q <= alu_result;
            rd_q         <= rd;
            mem_to_reg_q <= mem_to_reg;
            reg_write_q  <= reg_write;
        end
    end

    assign out.valid      = full;
    assign out.alu_result = alu_result_q;
    assign out.rd         = rd_q;
    assign out.mem_to_reg = mem_to_reg_q;
    assign out.reg_write  = reg_write_q;

    // a stalled entry must not change under the writeback stage
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (reset_n)
        (out.valid && !out.ready) |=>
            (out.valid && $stable(out.alu_result) && $stable(out.rd) &&
             $stable(out.mem_to_reg) && $stable(out.reg_write))
    ) else $error("mem_wb_reg entry changed while stalled");

endmodule

// ==== hw/data_memory.sv ====
`timescale 1ns/100ps

module data_memory (
    input  logic                            clk,
    input  logic                            accept,
    input  logic                            mem_read,
    input  logic                            mem_write,
    input  logic [cpu_pkg::word_size-1:0]   addr,
    input  logic [cpu_pkg::word_size-1:0]   store_data,
    output logic [cpu_pkg::word_size-1:0]   load_data
);

    logic [cpu_pkg::word_size-1:0]  ram [cpu_pkg::mem_depth];
    logic [cpu_pkg::mem_addr_w-1:0] word_addr;

    // upper address bits are ignored, the RAM wraps
    assign word_addr = addr[cpu_pkg::mem_addr_w-1:0];

    // a store lands at its accept edge so any later load sees it
    always_ff @(posedge clk) begin
        if (accept && mem_write) begin
            ram[word_addr] <= store_data;
        end
    end

    // load data is registered and then held until the next load is accepted
    always_ff @(posedge clk) begin
        if (accept && mem_read) begin
            load_data <= ram[word_addr];
        end
    end

    initial begin
        assert (cpu_pkg::mem_geom_ok)
        else $fatal(1, "data memory depth does not match its address width");
    end

    // execute never issues a load and a store in one instruction
    a_no_read_write: assert property (
        @(posedge clk) accept |-> !(mem_read && mem_write)
    ) else $error("load and store accepted together at %h", addr);

endmodule

// ==== hw/writeback.sv ====
`timescale 1ns/100ps

module writeback (
    input  logic                            clk,
    input  logic                            reset_n,
    stage_if.sink                           in,
    input  logic [cpu_pkg::word_size-1:0]   load_data,
    output logic                            wb_valid,
    input  logic                            wb_ready,
    output cpu_pkg::reg_idx_t               wb_rd,
    output logic                            wb_write,
    output logic [cpu_pkg::word_size-1:0]   wb_data,
    input  cpu_pkg::reg_idx_t               rs_addr,
    output logic [cpu_pkg::word_size-1:0]   rs_data
);

    logic [cpu_pkg::word_size-1:0]  regs [cpu_pkg::num_regs];
    logic [cpu_pkg::word_size-1:0]  result;
    logic                           commit;

    // loads take the memory word, everything else the ALU result
    assign result = in.mem_to_reg ? load_data : in.alu_result;

    // the commit port is the stage handshake seen from outside
    assign wb_valid = in.valid;
    assign in.ready = wb_ready;
    assign wb_rd    = in.rd;
    assign wb_write = in.reg_write;
    assign wb_data  = result;

    assign commit = wb_valid && wb_ready;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < cpu_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && in.reg_write) begin
            regs[in.rd] <= result;
        end
    end

    // the read port shows a commit only from the following edge on
    assign rs_data = regs[rs_addr];

    // nothing may be offered for commit straight out of reset
    a_idle_after_reset: assert property (
        @(posedge clk) reset_n |=> !wb_valid
    ) else $error("wb_valid high right after reset");

endmodule

// ==== hw/mem_wb_top.sv ====
`timescale 1ns/100ps

module mem_wb_top (
    input  logic                            clk,
    input  logic                            reset_n,

    // result from the execute stage
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [cpu_pkg::word_size-1:0]   alu_result,
    input  logic [cpu_pkg::word_size-1:0]   store_data,
    input  cpu_pkg::reg_idx_t               rd,
    input  logic                            mem_read,
    input  logic                            mem_write,
    input  logic                            mem_to_reg,
    input  logic                            reg_write,

    // commit port
    output logic                            wb_valid,
    input  logic                            wb_ready,
    output cpu_pkg::reg_idx_t               wb_rd,
    output logic                            wb_write,
    output logic [cpu_pkg::word_size-1:0]   wb_data,

    // architectural register read port
    input  cpu_pkg::reg_idx_t               rs_addr,
    output logic [cpu_pkg::word_size-1:0]   rs_data
);

    logic                           accept;
    logic [cpu_pkg::word_size-1:0]  load_data;

    stage_if stage ();

    mem_wb_reg u_mem_wb_reg (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .alu_result (alu_result),
        .rd         (rd),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .accept     (accept),
        .out        (stage.source)
    );

    // the ALU result doubles as the memory address
    data_memory u_data_memory (
        .clk        (clk),
        .accept     (accept),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .addr       (alu_result),
        .store_data (store_data),
        .load_data  (load_data)
    );

    writeback u_writeback (
        .clk        (clk),
        .reset_n    (reset_n),
        .in         (stage.sink),
        .load_data  (load_data),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_rd      (wb_rd),
        .wb_write   (wb_write),
        .wb_data    (wb_data),
        .rs_addr    (rs_addr),
        .rs_data    (rs_data)
    );

endmodule

// ==== verif/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic reset_n
);

    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                 // 10 ns period
    end

    // reset is active while reset_n is high
    initial begin
        reset_n = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b0;
    end

endmodule

// ==== verif/wb_checker.sv ====
`timescale 1ns/100ps

module wb_checker (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            in_valid,
    input  logic                            in_ready,
    input  logic [cpu_pkg::word_size-1:0]   alu_result,
    input  logic [cpu_pkg::word_size-1:0]   store_data,
    input  cpu_pkg::reg_idx_t               rd,
    input  logic                            mem_read,
    input  logic                            mem_write,
    input  logic                            mem_to_reg,
    input  logic                            reg_write,
    input  logic                            wb_valid,
    input  logic                            wb_ready,
    input  cpu_pkg::reg_idx_t               wb_rd,
    input  logic                            wb_write,
    input  logic [cpu_pkg::word_size-1:0]   wb_data,
    input  cpu_pkg::reg_idx_t               rs_addr,
    input  logic [cpu_pkg::word_size-1:0]   rs_data,
    output int                              mismatch_count,
    output int                              fault_count,
    output int                              commit_count,
    output int                              pending
);

    logic [cpu_pkg::word_size-1:0]  mem_model [cpu_pkg::mem_depth];
    bit                             mem_known [cpu_pkg::mem_depth];
    logic [cpu_pkg::word_size-1:0]  reg_model [cpu_pkg::num_regs];
    logic [cpu_pkg::word_size-1:0]  last_load;      // the load register holds between loads

    // expected commits in acceptance order
    cpu_pkg::reg_idx_t              exp_rd [$];
    logic                           exp_write [$];
    logic [cpu_pkg::word_size-1:0]  exp_data [$];

    logic                           stalled;
    cpu_pkg::reg_idx_t              held_rd;
    logic                           held_write;
    logic [cpu_pkg::word_size-1:0]  held_data;

    initial begin
        mismatch_count = 0;
        fault_count    = 0;
        commit_count   = 0;
        pending        = 0;
        stalled        = 1'b0;
    end

    task automatic compare_field(input string name, input logic [cpu_pkg::word_size-1:0] expected,
                                 input logic [cpu_pkg::word_size-1:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch %s at %0t: expected %h, got %h", name, $time, expected, actual);
        end
    endtask

    // everything is sampled mid-cycle, where the DUT outputs have settled
    always @(negedge clk) begin : watch
        logic [cpu_pkg::mem_addr_w-1:0] addr;
        logic [cpu_pkg::word_size-1:0]  value;
        if (reset_n) begin
            for (int i = 0; i < cpu_pkg::num_regs; i++) reg_model[i] = '0;
            for (int i = 0; i < cpu_pkg::mem_depth; i++) mem_known[i] = 1'b0;
            exp_rd.delete();
            exp_write.delete();
            exp_data.delete();
            stalled = 1'b0;
        end else begin
            compare_field("rs_data", reg_model[rs_addr], rs_data);
            if (stalled) begin                  // nothing moved at the last edge
                compare_field("wb_valid", 1'b1, wb_valid);
                compare_field("wb_rd", held_rd, wb_rd);
                compare_field("wb_write", held_write, wb_write);
                compare_field("wb_data", held_data, wb_data);
            end
            if (wb_valid && !wb_ready && in_ready) begin
                fault_count++;
                $display("in_ready is high at %0t while the commit port is stalled", $time);
            end
            if (wb_valid && wb_ready) begin
                if (exp_data.size() == 0) begin
                    fault_count++;
                    $display("commit at %0t with no result outstanding", $time);
                end else begin
                    compare_field("wb_rd", exp_rd[0], wb_rd);
                    compare_field("wb_write", exp_write[0], wb_write);
                    compare_field("wb_data", exp_data[0], wb_data);
                    if (exp_write[0]) reg_model[exp_rd[0]] = exp_data[0];
                    void'(exp_rd.pop_front());
                    void'(exp_write.pop_front());
                    void'(exp_data.pop_front());
                    commit_count++;
                end
            end
            if (in_valid && in_ready) begin
                addr = alu_result[cpu_pkg::mem_addr_w-1:0];
                if (mem_read) begin
                    if (!mem_known[addr]) begin
                        fault_count++;
                        $display("load at %0t from address %h that was never stored", $time, addr);
                    end
                    last_load = mem_model[addr];    // memory as it stands before this edge
                end
                value = mem_to_reg ? last_load : alu_result;
                if (mem_write) begin
                    mem_model[addr] = store_data;
                    mem_known[addr] = 1'b1;
                end
                exp_rd.push_back(rd);
                exp_write.push_back(reg_write);
                exp_data.push_back(value);
            end
            stalled    = wb_valid && !wb_ready;
            held_rd    = wb_rd;
            held_write = wb_write;
            held_data  = wb_data;
            pending    = exp_data.size();
        end
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

    localparam int num_results    = 400;
    localparam int reset_cycles   = 8;
    localparam int timeout_cycles = num_results * 20 + reset_cycles;
    localparam int init_stores    = 16;     // fills every used address before the random mix

    logic                           clk;
    logic                           reset_n;
    logic                           in_valid;
    logic                           in_ready;
    logic [cpu_pkg::word_size-1:0]  alu_result;
    logic [cpu_pkg::word_size-1:0]  store_data;
    cpu_pkg::reg_idx_t              rd;
    logic                           mem_read;
    logic                           mem_write;
    logic                           mem_to_reg;
    logic                           reg_write;
    logic                           wb_valid;
    logic                           wb_ready;
    cpu_pkg::reg_idx_t              wb_rd;
    logic                           wb_write;
    logic [cpu_pkg::word_size-1:0]  wb_data;
    cpu_pkg::reg_idx_t              rs_addr;
    logic [cpu_pkg::word_size-1:0]  rs_data;

    int     mismatch_count;
    int     fault_count;
    int     commit_count;
    int     pending;
    int     end_faults;
    int     issued;
    int     accepted;
    integer seed;
    logic   taken;
    logic   draining;
    logic   last_was_store;
    logic [3:0] last_store_addr;

    clock_gen u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    mem_wb_top DUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .alu_result (alu_result),
        .store_data (store_data),
        .rd         (rd),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .wb_valid   (wb_valid),
        .wb_ready   (wb_ready),
        .wb_rd      (wb_rd),
        .wb_write   (wb_write),
        .wb_data    (wb_data),
        .rs_addr    (rs_addr),
        .rs_data    (rs_data)
    );

    wb_checker u_wb_checker (.*);

    // kinds: 0 store, 1 load into a register, 2 ALU write, 3 no write
    task automatic next_result();
        int                             kind;
        logic [cpu_pkg::word_size-1:0]  value;
        logic [3:0]                     addr_lo;
        value   = $random(seed);
        kind    = {$random(seed)} % 4;
        addr_lo = value[3:0];
        if (issued < init_stores) begin
            kind    = 0;
            addr_lo = issued;
        end else if (kind == 1 && last_was_store && value[4]) begin
            addr_lo = last_store_addr;          // half the loads behind a store read that word
        end
        alu_result <= {value[15:8], 4'h0, addr_lo};      // only 16 words are ever addressed
        store_data <= $random(seed);
        rd         <= $random(seed);
        mem_read   <= (kind == 1);
        mem_write  <= (kind == 0);
        mem_to_reg <= (kind == 1);
        reg_write  <= (kind == 1) || (kind == 2);
        in_valid   <= 1'b1;
        last_was_store  = (kind == 0);
        last_store_addr = addr_lo;
        issued++;
    endtask

    initial begin
        seed       = 89;
        issued     = 0;
        accepted   = 0;
        end_faults = 0;
        last_was_store  = 1'b0;
        last_store_addr = '0;
        in_valid   = 1'b0;
        alu_result = '0;
        store_data = '0;
        rd         = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        wb_ready   = 1'b0;
        rs_addr    = '0;
        do @(posedge clk); while (reset_n);
        while (accepted < num_results) begin
            @(negedge clk);
            taken = in_valid && in_ready;
            @(posedge clk);
            if (taken) accepted++;
            if (!in_valid || taken) begin           // an offer is held until it is taken
                if (issued < num_results && ({$random(seed)} % 2) == 0) next_result();
                else in_valid <= 1'b0;
            end
            wb_ready <= ({$random(seed)} % 10) < 7;
            rs_addr  <= $random(seed);
        end
        draining = 1'b1;
        while (draining) begin
            @(negedge clk);
            if (!wb_valid) draining = 1'b0;
            @(posedge clk);
            wb_ready <= ({$random(seed)} % 10) < 7;
            rs_addr  <= $random(seed);
        end
        for (int i = 0; i < cpu_pkg::num_regs; i++) begin
            @(posedge clk);
            rs_addr <= i;
        end
        repeat (2) @(posedge clk);
        if (pending != 0 || commit_count != num_results) begin
            end_faults++;
            $display("%0d results committed out of %0d accepted", commit_count, num_results);
        end
        $display("errors: %0d mismatch, %0d other, %0d results committed",
                 mismatch_count, fault_count + end_faults, commit_count);
        if (mismatch_count + fault_count + end_faults == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== build.f ====
hw/cpu_pkg.sv
hw/stage_if.sv
hw/mem_wb_reg.sv
hw/data_memory.sv
hw/writeback.sv
hw/mem_wb_top.sv
verif/clock_gen.sv
verif/wb_checker.sv
verif/tb_top.sv

// ==== Bender.yml ====
package:
  name: mem_wb_backend

sources:
  - files:
      - hw/cpu_pkg.sv
      - hw/stage_if.sv
      - hw/mem_wb_reg.sv
      - hw/data_memory.sv
      - hw/writeback.sv
      - hw/mem_wb_top.sv
  - target: simulation
    files:
      - verif/clock_gen.sv
      - verif/wb_checker.sv
      - verif/tb_top.sv
